// File: Makefile
# Verilator build and run of the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= bp_frontend_tb
FILELIST  ?= project.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD)

// File: include/bp_macros.svh
//==========================================================
// sizing constants for the static branch predictor
// include wherever a slot count, stack depth or address
// width is needed; the packages hold the types built on them
//==========================================================
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// instructions per aligned fetch group
// 4 slots of 4 bytes, no compressed forms
`define BP_SLOTS 4

// return address stack entries
// ring buffer, oldest entry lost on overflow
`define BP_RAS_DEPTH 8

// virtual address width
`define BP_XLEN 64

`endif

// File: project.f
+incdir+include
source/bp_isa_pkg.sv
source/bp_frontend_pkg.sv
source/fetch_slicer.sv
source/predecode.sv
source/ras.sv
source/branch_select.sv
source/bp_frontend.sv
tb/bp_frontend_chk.sv
tb/bp_frontend_tb.sv

// File: source/bp_frontend.sv
//==========================================================
// static branch predictor top level
// fetch group in, one registered prediction per group out,
// two cycles later; stall_o tells fetch to stop presenting
// groups until a pending jalr has been resolved
//==========================================================
`timescale 1ns/100ps
`include "bp_macros.svh"

module bp_frontend (
	input  logic                               CLK,
	input  logic                               reset_i,
	input  logic                               flush_i,
	input  logic                               fetch_valid_i,
	input  bp_frontend_pkg::addr_t             fetch_pc_i,
	input  bp_isa_pkg::instr_t [`BP_SLOTS-1:0] fetch_data_i,
	input  logic                               jalr_valid_i,
	input  bp_frontend_pkg::addr_t             jalr_pc_i,
	output logic                               pred_valid_o,
	output bp_frontend_pkg::prediction_t       pred_o,
	output logic                               stall_o
);

	bp_frontend_pkg::slot_t [`BP_SLOTS-1:0]      slots;
	bp_frontend_pkg::predecode_t [`BP_SLOTS-1:0] pd;
	logic                                        hold;
	logic                                        ras_push;
	logic                                        ras_pop;
	bp_frontend_pkg::addr_t                      ras_push_addr;
	bp_frontend_pkg::addr_t                      ras_top;
	logic                                        ras_empty;

	// stage 1, group register
	fetch_slicer i_slicer (
		.CLK           (CLK),
		.reset_i       (reset_i),
		.flush_i       (flush_i),
		.hold_i        (hold),
		.fetch_valid_i (fetch_valid_i),
		.fetch_pc_i    (fetch_pc_i),
		.fetch_data_i  (fetch_data_i),
		.slots_o       (slots)
	);

	// all slots classified in parallel
	for (genvar s = 0; s < `BP_SLOTS; s++) begin : g_pd
		predecode i_predecode (
			.slot_i (slots[s]),
			.pd_o   (pd[s])
		);
	end

	// stage 2, selection and prediction register
	branch_select i_select (
		.CLK             (CLK),
		.reset_i         (reset_i),
		.flush_i         (flush_i),
		.slots_i         (slots),
		.pd_i            (pd),
		.jalr_valid_i    (jalr_valid_i),
		.jalr_pc_i       (jalr_pc_i),
		.ras_empty_i     (ras_empty),
		.ras_top_i       (ras_top),
		.ras_push_o      (ras_push),
		.ras_pop_o       (ras_pop),
		.ras_push_addr_o (ras_push_addr),
		.hold_o          (hold),
		.pred_valid_o    (pred_valid_o),
		.pred_o          (pred_o),
		.stall_o         (stall_o)
	);

	ras i_ras (
		.CLK         (CLK),
		.reset_i     (reset_i),
		.flush_i     (flush_i),
		.push_i      (ras_push),
		.pop_i       (ras_pop),
		.push_addr_i (ras_push_addr),
		.top_addr_o  (ras_top),
		.empty_o     (ras_empty)
	);

endmodule

// File: source/bp_frontend_pkg.sv
//==========================================================
// front-end types shared by slicer, predecoders, selector
// and stack: addresses, slots, predecode results and the
// registered prediction handed back to fetch
//==========================================================
`include "bp_macros.svh"

package bp_frontend_pkg;

	// fetch address and slot position inside a group
	typedef logic [`BP_XLEN-1:0] addr_t;
	typedef logic [$clog2(`BP_SLOTS)-1:0] slot_idx_t;

	// one instruction slot as seen after the slicer
	typedef struct packed {
		logic               valid;
		addr_t              pc;
		bp_isa_pkg::instr_t instr;
	} slot_t;

	// per-slot classification
	// imm already sign extended to full width
	typedef struct packed {
		logic                 valid;
		bp_isa_pkg::cf_kind_e kind;
		addr_t                imm;
		logic                 is_call;
		logic                 is_return;
	} predecode_t;

	// result towards fetch
	// slot is the last slot consumed by the group
	typedef struct packed {
		addr_t                next_pc;
		slot_idx_t            slot;
		bp_isa_pkg::cf_kind_e kind;
		logic                 taken;
		logic                 from_ras;
	} prediction_t;

	// selector FSM
	typedef enum logic {
		SEL_IDLE,
		SEL_WAIT_JALR
	} sel_state_e;

endpackage

// File: source/bp_isa_pkg.sv
//==========================================================
// RISC-V encoding view used by the predecoders
// opcodes, register fields and the control-flow classes
// referenced as bp_isa_pkg::name
//==========================================================
package bp_isa_pkg;

	// base ISA only, every instruction is 32 bits
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;

	// major opcodes that redirect fetch
	localparam opcode_t OPCODE_BRANCH = 7'b1100011;
	localparam opcode_t OPCODE_JAL    = 7'b1101111;
	localparam opcode_t OPCODE_JALR   = 7'b1100111;

	// link registers of the calling convention
	localparam reg_idx_t REG_RA = 5'd1;
	localparam reg_idx_t REG_T0 = 5'd5;

	// what a slot does to the fetch stream
	typedef enum logic [1:0] {
		CF_NONE,
		CF_BRANCH,
		CF_JAL,
		CF_JALR
	} cf_kind_e;

	function automatic opcode_t opcode_of(instr_t instr);
		return instr[6:0];
	endfunction

	function automatic reg_idx_t rd_of(instr_t instr);
		return instr[11:7];
	endfunction

	function automatic reg_idx_t rs1_of(instr_t instr);
		return instr[19:15];
	endfunction

	// x1 or x5 marks a call or a return
	function automatic logic is_link(reg_idx_t r);
		return (r == REG_RA) || (r == REG_T0);
	endfunction

endpackage

// File: source/branch_select.sv
//==========================================================
// prediction stage of the fetch front end
// scans the predecoded slots for the first redirect, drives
// the return stack and registers the prediction; a jalr
// without a usable stack entry parks the FSM until the back
// end resolves it, holding the slicer meanwhile
//==========================================================
`timescale 1ns/100ps
`include "bp_macros.svh"

module branch_select (
	input  logic                                        CLK,
	input  logic                                        reset_i,
	input  logic                                        flush_i,
	input  bp_frontend_pkg::slot_t [`BP_SLOTS-1:0]      slots_i,
	input  bp_frontend_pkg::predecode_t [`BP_SLOTS-1:0] pd_i,
	input  logic                                        jalr_valid_i,
	input  bp_frontend_pkg::addr_t                      jalr_pc_i,
	input  logic                                        ras_empty_i,
	input  bp_frontend_pkg::addr_t                      ras_top_i,
	output logic                                        ras_push_o,
	output logic                                        ras_pop_o,
	output bp_frontend_pkg::addr_t                      ras_push_addr_o,
	output logic                                        hold_o,
	output logic                                        pred_valid_o,
	output bp_frontend_pkg::prediction_t                pred_o,
	output logic                                        stall_o
);

	localparam int SLOTS       = `BP_SLOTS;
	localparam int GROUP_BYTES = `BP_SLOTS * 4;

	bp_frontend_pkg::sel_state_e  state_q;
	bp_frontend_pkg::prediction_t pred_q;
	logic                         pred_valid_q;
	logic                         group_valid;
	logic                         hit;
	bp_frontend_pkg::slot_idx_t   hit_slot;
	bp_frontend_pkg::predecode_t  hit_pd;
	bp_frontend_pkg::addr_t       hit_pc;
	logic                         scan_en;
	logic                         use_ras;
	logic                         need_wait;
	logic                         waiting;
	bp_frontend_pkg::prediction_t scan_pred;

	// priority scan, walk downwards so the lowest slot wins
	always_comb begin
		group_valid = 1'b0;
		hit         = 1'b0;
		hit_slot    = bp_frontend_pkg::slot_idx_t'(SLOTS - 1);
		hit_pd      = pd_i[SLOTS-1];
		hit_pc      = slots_i[SLOTS-1].pc;
		for (int s = SLOTS - 1; s >= 0; s--) begin
			group_valid = group_valid | pd_i[s].valid;
			// jumps always redirect, branches only when backward
			if (pd_i[s].valid && ((pd_i[s].kind == bp_isa_pkg::CF_JAL)
				|| (pd_i[s].kind == bp_isa_pkg::CF_JALR)
				|| ((pd_i[s].kind == bp_isa_pkg::CF_BRANCH) && pd_i[s].imm[`BP_XLEN-1]))) begin
				hit      = 1'b1;
				hit_slot = bp_frontend_pkg::slot_idx_t'(s);
				hit_pd   = pd_i[s];
				hit_pc   = slots_i[s].pc;
			end
		end
	end

	assign waiting   = (state_q == bp_frontend_pkg::SEL_WAIT_JALR);
	assign scan_en   = !waiting && group_valid;
	// return with something on the stack resolves here
	assign use_ras   = hit && (hit_pd.kind == bp_isa_pkg::CF_JALR) && hit_pd.is_return
		&& !ras_empty_i;
	// any other jalr needs the register value
	assign need_wait = hit && (hit_pd.kind == bp_isa_pkg::CF_JALR) && !use_ras;

	// stack side effects happen once, when the group is scanned
	assign ras_push_o      = scan_en && hit && hit_pd.is_call;
	assign ras_pop_o       = scan_en && use_ras;
	assign ras_push_addr_o = hit_pc + bp_frontend_pkg::addr_t'(4);

	always_comb begin
		if (hit) begin
			scan_pred.next_pc  = use_ras ? ras_top_i : hit_pc + hit_pd.imm;
			scan_pred.slot     = hit_slot;
			scan_pred.kind     = hit_pd.kind;
			scan_pred.taken    = 1'b1;
			scan_pred.from_ras = use_ras;
		end else begin
			// fall through to the next aligned group
			scan_pred.next_pc  = slots_i[0].pc + bp_frontend_pkg::addr_t'(GROUP_BYTES);
			scan_pred.slot     = bp_frontend_pkg::slot_idx_t'(SLOTS - 1);
			scan_pred.kind     = bp_isa_pkg::CF_NONE;
			scan_pred.taken    = 1'b0;
			scan_pred.from_ras = 1'b0;
		end
	end

	// FSM and output strobe
	always_ff @(posedge CLK) begin
		if (reset_i || flush_i) begin
			state_q      <= bp_frontend_pkg::SEL_IDLE;
			pred_valid_q <= 1'b0;
		end else begin
			pred_valid_q <= 1'b0;
			case (state_q)
				bp_frontend_pkg::SEL_IDLE: begin
					if (group_valid && need_wait) begin
						state_q <= bp_frontend_pkg::SEL_WAIT_JALR;
					end else if (group_valid) begin
						pred_valid_q <= 1'b1;
					end
				end
				bp_frontend_pkg::SEL_WAIT_JALR: begin
					if (jalr_valid_i) begin
						state_q      <= bp_frontend_pkg::SEL_IDLE;
						pred_valid_q <= 1'b1;
					end
				end
				default: state_q <= bp_frontend_pkg::SEL_IDLE;
			endcase
		end
	end

	// pending jalr keeps slot and kind, target patched on resolve
	always_ff @(posedge CLK) begin
		if (scan_en) begin
			pred_q <= scan_pred;
		end else if (waiting && jalr_valid_i) begin
			pred_q.next_pc <= jalr_pc_i;
		end
	end

	assign hold_o       = waiting;
	assign stall_o      = waiting;
	assign pred_valid_o = pred_valid_q;
	assign pred_o       = pred_q;

endmodule

// File: source/fetch_slicer.sv
//==========================================================
// input register of the predictor
// captures one aligned fetch group and presents it as
// per-slot pc, instruction and valid; slots ahead of the
// start pc are masked off. hold_i freezes the stage
//==========================================================
`timescale 1ns/100ps
`include "bp_macros.svh"

module fetch_slicer (
	input  logic                                    CLK,
	input  logic                                    reset_i,
	input  logic                                    flush_i,
	input  logic                                    hold_i,
	input  logic                                    fetch_valid_i,
	input  bp_frontend_pkg::addr_t                  fetch_pc_i,
	input  bp_isa_pkg::instr_t [`BP_SLOTS-1:0]      fetch_data_i,
	output bp_frontend_pkg::slot_t [`BP_SLOTS-1:0]  slots_o
);

	localparam int SLOTS       = `BP_SLOTS;
	localparam int SLOT_W      = $clog2(`BP_SLOTS);
	localparam int GROUP_BYTES = `BP_SLOTS * 4;

	bp_frontend_pkg::addr_t     base_q;
	bp_isa_pkg::instr_t [SLOTS-1:0] data_q;
	logic [SLOTS-1:0]           mask_q;
	logic [SLOTS-1:0]           mask_d;
	bp_frontend_pkg::slot_idx_t start_slot;
	logic                       load;

	// word offset of the start pc inside the group
	assign start_slot = fetch_pc_i[2 +: SLOT_W];
	assign load       = fetch_valid_i & ~hold_i;

	// slots at or after the entry point are live
	always_comb begin
		for (int s = 0; s < SLOTS; s++) begin
			mask_d[s] = (bp_frontend_pkg::slot_idx_t'(s) >= start_slot);
		end
	end

	// valid mask is the only control state here
	always_ff @(posedge CLK) begin
		if (reset_i || flush_i) begin
			mask_q <= '0;
		end else if (!hold_i) begin
			mask_q <= fetch_valid_i ? mask_d : '0;
		end
	end

	// group payload, only follows a new fetch
	always_ff @(posedge CLK) begin
		if (load) begin
			base_q <= fetch_pc_i & ~bp_frontend_pkg::addr_t'(GROUP_BYTES - 1);
			data_q <= fetch_data_i;
		end
	end

	// slot pc from aligned base plus 4 per slot
	always_comb begin
		for (int s = 0; s < SLOTS; s++) begin
			slots_o[s].valid = mask_q[s];
			slots_o[s].pc    = base_q + bp_frontend_pkg::addr_t'(s * 4);
			slots_o[s].instr = data_q[s];
		end
	end

endmodule

// File: source/predecode.sv
//==========================================================
// single-slot predecoder, purely combinational
// classifies the instruction, builds its branch or jump
// immediate and flags calls and returns; one instance per
// slot of the fetch group
//==========================================================
`timescale 1ns/100ps
`include "bp_macros.svh"

module predecode (
	input  bp_frontend_pkg::slot_t      slot_i,
	output bp_frontend_pkg::predecode_t pd_o
);

	bp_isa_pkg::instr_t     instr;
	bp_isa_pkg::opcode_t    opcode;
	bp_isa_pkg::reg_idx_t   rd;
	bp_isa_pkg::reg_idx_t   rs1;
	bp_isa_pkg::cf_kind_e   kind;
	bp_frontend_pkg::addr_t imm_b;
	bp_frontend_pkg::addr_t imm_j;
	bp_frontend_pkg::addr_t imm_i;

	assign instr  = slot_i.instr;
	assign opcode = bp_isa_pkg::opcode_of(instr);
	assign rd     = bp_isa_pkg::rd_of(instr);
	assign rs1    = bp_isa_pkg::rs1_of(instr);

	// B-type, offset in multiples of 2
	assign imm_b = {{(`BP_XLEN - 13){instr[31]}}, instr[31], instr[7],
		instr[30:25], instr[11:8], 1'b0};

	// J-type, 21-bit signed offset
	assign imm_j = {{(`BP_XLEN - 21){instr[31]}}, instr[31], instr[19:12],
		instr[20], instr[30:21], 1'b0};

	// I-type for jalr, only meaningful once rs1 is known
	assign imm_i = {{(`BP_XLEN - 12){instr[31]}}, instr[31:20]};

	// opcode only, funct3 not checked
	always_comb begin
		case (opcode)
			bp_isa_pkg::OPCODE_BRANCH: kind = bp_isa_pkg::CF_BRANCH;
			bp_isa_pkg::OPCODE_JAL:    kind = bp_isa_pkg::CF_JAL;
			bp_isa_pkg::OPCODE_JALR:   kind = bp_isa_pkg::CF_JALR;
			default:                   kind = bp_isa_pkg::CF_NONE;
		endcase
	end

	always_comb begin
		pd_o.valid = slot_i.valid;
		pd_o.kind  = kind;
		case (kind)
			bp_isa_pkg::CF_BRANCH: pd_o.imm = imm_b;
			bp_isa_pkg::CF_JAL:    pd_o.imm = imm_j;
			bp_isa_pkg::CF_JALR:   pd_o.imm = imm_i;
			default:               pd_o.imm = '0;
		endcase
		// call: any jump that links through x1 or x5
		pd_o.is_call = ((kind == bp_isa_pkg::CF_JAL) || (kind == bp_isa_pkg::CF_JALR))
			&& bp_isa_pkg::is_link(rd);
		// return: jalr via link reg, but not a coroutine swap onto itself
		pd_o.is_return = (kind == bp_isa_pkg::CF_JALR) && bp_isa_pkg::is_link(rs1)
			&& (rs1 != rd);
	end

endmodule

// File: source/ras.sv
//==========================================================
// return address stack as a ring buffer
// push on overflow drops the oldest entry; pop and push in
// the same cycle replace the top. flush empties the stack
//==========================================================
`timescale 1ns/100ps
`include "bp_macros.svh"

module ras (
	input  logic                   CLK,
	input  logic                   reset_i,
	input  logic                   flush_i,
	input  logic                   push_i,
	input  logic                   pop_i,
	input  bp_frontend_pkg::addr_t push_addr_i,
	output bp_frontend_pkg::addr_t top_addr_o,
	output logic                   empty_o
);

	localparam int DEPTH = `BP_RAS_DEPTH;
	localparam int PTR_W = $clog2(`BP_RAS_DEPTH);
	localparam int CNT_W = $clog2(`BP_RAS_DEPTH + 1);

	typedef logic [PTR_W-1:0] ras_ptr_t;
	typedef logic [CNT_W-1:0] ras_cnt_t;

	bp_frontend_pkg::addr_t stack_q [DEPTH];
	ras_ptr_t               top_q;
	ras_cnt_t               count_q;
	ras_ptr_t               top_inc;
	ras_ptr_t               top_dec;

	// wrap explicitly so depth need not be a power of two
	assign top_inc = (top_q == ras_ptr_t'(DEPTH - 1)) ? '0 : top_q + 1'b1;
	assign top_dec = (top_q == '0) ? ras_ptr_t'(DEPTH - 1) : top_q - 1'b1;

	always_ff @(posedge CLK) begin
		if (reset_i || flush_i) begin
			top_q   <= '0;
			count_q <= '0;
		end else if (push_i && !pop_i) begin
			top_q <= top_inc;
			// saturate, a full push overwrites the oldest slot
			if (count_q != ras_cnt_t'(DEPTH)) begin
				count_q <= count_q + 1'b1;
			end
		end else if (pop_i && !push_i && (count_q != '0)) begin
			top_q   <= top_dec;
			count_q <= count_q - 1'b1;
		end
	end

	// push alone writes above top, push with pop overwrites top
	always_ff @(posedge CLK) begin
		if (push_i) begin
			stack_q[pop_i ? top_q : top_inc] <= push_addr_i;
		end
	end

	assign top_addr_o = stack_q[top_q];
	assign empty_o    = (count_q == '0);

endmodule

// File: tb/bp_frontend_chk.sv
//==========================================================
// concurrent checks on the prediction stage
// bound into branch_select from the testbench; watches the
// output strobe, the stall level and target alignment
//==========================================================
`timescale 1ns/100ps
`include "bp_macros.svh"

module bp_frontend_chk (
	input logic                                        CLK,
	input logic                                        reset_i,
	input bp_frontend_pkg::predecode_t [`BP_SLOTS-1:0] pd_i,
	input logic                                        pred_valid_o,
	input bp_frontend_pkg::prediction_t                pred_o,
	input logic                                        stall_o
);

	logic seen_group_q;
	logic any_valid;

	// some slot of a group reached the selector
	always_comb begin
		any_valid = 1'b0;
		for (int s = 0; s < `BP_SLOTS; s++) begin
			any_valid = any_valid | pd_i[s].valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset_i) begin
			seen_group_q <= 1'b0;
		end else if (any_valid) begin
			seen_group_q <= 1'b1;
		end
	end

	// stall is a level, a pulse never overlaps it
	a_no_overlap: assert property (@(posedge CLK) disable iff (reset_i)
		!(stall_o && pred_valid_o))
		else $error("stall and prediction strobe high together");

	// quiet outputs until the first group
	a_quiet_after_reset: assert property (@(posedge CLK) disable iff (reset_i)
		!seen_group_q |-> (!pred_valid_o && !stall_o))
		else $error("output activity before any fetch group");

	// no compressed code, so targets are word aligned
	a_aligned: assert property (@(posedge CLK) disable iff (reset_i)
		pred_valid_o |-> (pred_o.next_pc[1:0] == 2'b00))
		else $error("prediction target not 4-byte aligned");

endmodule

// File: tb/bp_frontend_tb.sv
//==========================================================
// testbench for the static branch predictor
// directed groups for each prediction rule, then LFSR
// driven traffic, all checked against a reference model
// with its own return stack; run with project.f
//==========================================================
`timescale 1ns/100ps
`include "bp_macros.svh"

module bp_frontend_tb;

	typedef bp_isa_pkg::instr_t [`BP_SLOTS-1:0] group_t;
	localparam int TIMEOUT = 50;

	logic                         CLK;
	logic                         reset_i;
	logic                         flush_i;
	logic                         fetch_valid_i;
	bp_frontend_pkg::addr_t       fetch_pc_i;
	group_t                       fetch_data_i;
	logic                         jalr_valid_i;
	bp_frontend_pkg::addr_t       jalr_pc_i;
	logic                         pred_valid_o;
	bp_frontend_pkg::prediction_t pred_o;
	logic                         stall_o;

	logic [31:0]            lfsr_q;
	bp_frontend_pkg::addr_t ras_model[$];
	int                     checks;
	int                     errors;
	int                     err_mark;

	bp_frontend UUT (.*);

	bind branch_select bp_frontend_chk i_chk (
		.CLK (CLK), .reset_i (reset_i), .pd_i (pd_i),
		.pred_valid_o (pred_valid_o), .pred_o (pred_o), .stall_o (stall_o)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
		end
		return r;
	endfunction

	function automatic bp_frontend_pkg::addr_t rand_addr();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = rand_bits(32);
		lo = rand_bits(30);
		return {hi, lo[29:0], 2'b00};
	endfunction

	// encoders straight from the base ISA formats
	function automatic bp_isa_pkg::instr_t enc_branch(logic [12:0] off);
		return {off[12], off[10:5], 5'd2, 5'd3, 3'b000, off[4:1], off[11],
			bp_isa_pkg::OPCODE_BRANCH};
	endfunction

	function automatic bp_isa_pkg::instr_t enc_jal(logic [4:0] rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, bp_isa_pkg::OPCODE_JAL};
	endfunction

	function automatic bp_isa_pkg::instr_t enc_jalr(logic [4:0] rd, logic [4:0] rs1);
		return {12'd0, rs1, 3'b000, rd, bp_isa_pkg::OPCODE_JALR};
	endfunction

	// register set with both link registers in it
	function automatic logic [4:0] pick_reg();
		logic [1:0] k;
		k = 2'(rand_bits(2));
		case (k)
			2'd0: return 5'd0;
			2'd1: return 5'd1;
			2'd2: return 5'd5;
			default: return 5'd6;
		endcase
	endfunction

	// biased towards jumps with imm bit 1 cleared so targets stay aligned
	function automatic group_t random_group();
		group_t g;
		logic [31:0] r;
		logic [2:0] k;
		for (int s = 0; s < `BP_SLOTS; s++) begin
			r = rand_bits(32);
			k = 3'(rand_bits(3));
			case (k)
				3'd0, 3'd1: r[6:0] = 7'b0010011;
				3'd2, 3'd3: begin
					r[8]   = 1'b0;
					r[6:0] = bp_isa_pkg::OPCODE_BRANCH;
				end
				3'd4, 3'd5: begin
					r[21]   = 1'b0;
					r[11:7] = pick_reg();
					r[6:0]  = bp_isa_pkg::OPCODE_JAL;
				end
				default: r = enc_jalr(pick_reg(), pick_reg());
			endcase
			g[s] = r;
		end
		return g;
	endfunction

	function automatic logic link_reg(logic [4:0] r);
		return (r == 5'd1) || (r == 5'd5);
	endfunction

	// model stack drops its oldest entry past the depth
	task automatic model_push(input bp_frontend_pkg::addr_t a);
		ras_model.push_back(a);
		if (ras_model.size() > `BP_RAS_DEPTH) begin
			void'(ras_model.pop_front());
		end
	endtask

	// reference prediction from the scan rules
	task automatic model_predict(input bp_frontend_pkg::addr_t pc, input group_t g,
		output bp_frontend_pkg::prediction_t exp, output logic exp_stall);
		bp_frontend_pkg::addr_t base;
		bp_frontend_pkg::addr_t spc;
		bp_frontend_pkg::addr_t off;
		logic [31:0] ins;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic hit;
		base = pc & ~bp_frontend_pkg::addr_t'(15);
		exp.next_pc  = base + 64'd16;
		exp.slot     = 2'd3;
		exp.kind     = bp_isa_pkg::CF_NONE;
		exp.taken    = 1'b0;
		exp.from_ras = 1'b0;
		exp_stall    = 1'b0;
		hit          = 1'b0;
		for (int s = int'(pc[3:2]); (s < `BP_SLOTS) && !hit; s++) begin
			ins = g[s];
			rd  = ins[11:7];
			rs1 = ins[19:15];
			spc = base + bp_frontend_pkg::addr_t'(4 * s);
			exp.slot = bp_frontend_pkg::slot_idx_t'(s);
			if ((ins[6:0] == bp_isa_pkg::OPCODE_BRANCH) && ins[31]) begin
				hit = 1'b1;
				off = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				exp.kind    = bp_isa_pkg::CF_BRANCH;
				exp.next_pc = spc + off;
			end else if (ins[6:0] == bp_isa_pkg::OPCODE_JAL) begin
				hit = 1'b1;
				off = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				exp.kind    = bp_isa_pkg::CF_JAL;
				exp.next_pc = spc + off;
				if (link_reg(rd)) model_push(spc + 64'd4);
			end else if (ins[6:0] == bp_isa_pkg::OPCODE_JALR) begin
				hit = 1'b1;
				exp.kind = bp_isa_pkg::CF_JALR;
				// return pops first and a call then pushes on top
				if (link_reg(rs1) && (rs1 != rd) && (ras_model.size() > 0)) begin
					exp.next_pc  = ras_model.pop_back();
					exp.from_ras = 1'b1;
				end else begin
					exp_stall = 1'b1;
				end
				if (link_reg(rd)) model_push(spc + 64'd4);
			end
			if (hit) exp.taken = 1'b1;
		end
		if (!hit) exp.slot = 2'd3;
	endtask

	task automatic check_prediction(input bp_frontend_pkg::prediction_t got,
		input bp_frontend_pkg::prediction_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$write("[ERROR] %0d ns: %s: got pc=%h slot=%0d kind=%0d tk=%b ras=%b",
				$time, what, got.next_pc, got.slot, got.kind, got.taken, got.from_ras);
			$display(", want pc=%h slot=%0d kind=%0d tk=%b ras=%b",
				exp.next_pc, exp.slot, exp.kind, exp.taken, exp.from_ras);
		end
	endtask

	task automatic check_stall(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0d ns: %s: got %b, want %b", $time, what, got, exp);
		end
	endtask

	task automatic check_latency(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[ERROR] %0d ns: %s: latency %0d cycles, want %0d",
				$time, what, got, exp);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout: %s did not answer within %0d cycles", what, TIMEOUT);
		$display("*** FAILED ***");
		$finish;
	endtask

	// wait for a pulse or a stall and drop the fetch strobe after one cycle
	task automatic wait_response(input string what, output int cycles);
		cycles = 0;
		while (!(pred_valid_o || stall_o)) begin
			@(negedge CLK);
			fetch_valid_i = 1'b0;
			cycles++;
			if (cycles >= TIMEOUT) timeout_fail(what);
		end
	endtask

	task automatic pulse_flush();
		flush_i = 1'b1;
		@(negedge CLK);
		flush_i = 1'b0;
		ras_model.delete();
	endtask

	// one group through the pipe with a stall resolved after a random delay
	task automatic run_group(input bp_frontend_pkg::addr_t pc, input group_t g,
		input string what);
		bp_frontend_pkg::prediction_t exp;
		logic exp_stall;
		int cycles;
		int delay;
		model_predict(pc, g, exp, exp_stall);
		fetch_valid_i = 1'b1;
		fetch_pc_i    = pc;
		fetch_data_i  = g;
		wait_response(what, cycles);
		check_latency(cycles, 2, what);
		check_stall(stall_o, exp_stall, what);
		if (exp_stall) begin
			delay = int'(rand_bits(3));
			for (int i = 0; i < delay; i++) begin
				@(negedge CLK);
				check_stall(stall_o, 1'b1, {what, " wait"});
			end
			exp.next_pc  = rand_addr();
			jalr_valid_i = 1'b1;
			jalr_pc_i    = exp.next_pc;
			@(negedge CLK);
			jalr_valid_i = 1'b0;
			check_stall(stall_o, 1'b0, {what, " resolved"});
			check_stall(pred_valid_o, 1'b1, {what, " strobe"});
		end
		check_prediction(pred_o, exp, what);
		@(negedge CLK);
	endtask

	task automatic finish_test(input string name);
		$display("test %-24s %s", name, (errors == err_mark) ? "ok" : "mismatches");
		err_mark = errors;
	endtask

	initial begin
		group_t g;
		int cycles;
		lfsr_q        = 32'd25;
		checks        = 0;
		errors        = 0;
		err_mark      = 0;
		reset_i       = 1'b1;
		flush_i       = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_pc_i    = '0;
		fetch_data_i  = '0;
		jalr_valid_i  = 1'b0;
		jalr_pc_i     = '0;
		repeat (10) @(negedge CLK);
		reset_i = 1'b0;
		check_stall(stall_o, 1'b0, "stall after reset");
		check_stall(pred_valid_o, 1'b0, "strobe after reset");

		// plain code and forward branches fall through
		g = {4{32'h0000_0013}};
		run_group(64'h1000, g, "no flow");
		run_group(64'h2008, g, "no flow mid group");
		g = {enc_branch(13'd64), enc_branch(13'd8), 32'h0000_0013, enc_branch(13'd16)};
		run_group(64'h3004, g, "forward branches");
		finish_test("fall through");

		// earliest redirect wins and slot 0 before the start is masked
		g = {enc_jal(5'd0, 21'd256), enc_branch(-13'sd32), enc_branch(13'd8),
			enc_jal(5'd0, -21'sd64)};
		run_group(64'h4004, g, "backward branch first");
		g = {enc_branch(-13'sd16), enc_jal(5'd0, 21'h200), enc_branch(-13'sd32),
			enc_branch(-13'sd8)};
		run_group(64'h5008, g, "jal before branch");
		finish_test("first redirect");

		// ten calls overflow the stack so the last two returns stall
		for (int i = 0; i < 10; i++) begin
			g = {{3{32'h0000_0013}}, enc_jal(5'd1, 21'h400)};
			run_group(64'h10000 + 64'(i * 64), g, "call");
		end
		for (int i = 0; i < 10; i++) begin
			g = {4{enc_jalr(5'd0, 5'd1)}};
			run_group(64'h20000 + 64'(i * 64), g, "return");
		end
		finish_test("call and return");

		g = {4{enc_jalr(5'd0, 5'd6)}};
		run_group(64'h6000, g, "indirect jalr");
		g = {4{enc_jalr(5'd0, 5'd5)}};
		run_group(64'h6100, g, "return on empty");
		finish_test("jalr stall");

		// flush empties the stack and drops a pending wait
		g = {4{enc_jal(5'd5, 21'h80)}};
		run_group(64'h7000, g, "call before flush");
		pulse_flush();
		g = {4{enc_jalr(5'd0, 5'd5)}};
		run_group(64'h7100, g, "return after flush");
		g = {4{enc_jalr(5'd0, 5'd6)}};
		fetch_valid_i = 1'b1;
		fetch_pc_i    = 64'h7200;
		fetch_data_i  = g;
		wait_response("jalr before flush", cycles);
		check_stall(stall_o, 1'b1, "stall before flush");
		pulse_flush();
		check_stall(stall_o, 1'b0, "stall after flush");
		check_stall(pred_valid_o, 1'b0, "strobe after flush");
		@(negedge CLK);
		check_stall(pred_valid_o, 1'b0, "strobe later after flush");
		finish_test("flush");

		for (int i = 0; i < 300; i++) begin
			run_group(rand_addr(), random_group(), "random");
		end
		finish_test("random traffic");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
